// File: filelist.f
+incdir+common
common/armIsaPkg.sv
common/armCtrlPkg.sv
decode/instrDecoder.sv
src/pipeStage.sv
execute/condExecute.sv
src/flagsReg.sv
src/armCtrlTop.sv
tests/armCtrl_assertions.sv
tests/armCtrlChecker.sv
tests/armCtrlTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := armCtrlTb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
SIM_ARGS   := +verilator+error+limit+1000
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/armCtrlTb.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module armCtrlTb;

  localparam int          NUM_INSTR        = 400;
  localparam int          CYCLES_PER_INSTR = 6;   // Headroom for stalls, bubbles, drain
  localparam int          TIMEOUT_CYCLES   = NUM_INSTR * CYCLES_PER_INSTR;
  localparam int          RESET_CYCLES     = 10;
  localparam logic [31:0] SEED             = 32'he4e3adde;

  logic                       clk;
  logic                       reset;
  logic [`INSTR_WIDTH-1:0]    instr;
  logic                       instrValid;
  logic                       stall;
  logic [`FLAG_WIDTH-1:0]     aluFlags;
  logic [`ADDR_LOW_WIDTH-1:0] addrLow;
  logic [`ALU_CTRL_WIDTH-1:0] aluControlE;
  logic                       aluSrcE, branchTakenE;
  logic                       memWriteM, memToRegM;
  logic [`MASK_WIDTH-1:0]     byteMaskM;
  logic                       regWriteW, memToRegW;
  logic [`FLAG_WIDTH-1:0]     flags;
  int                         errorCount, checkCount, acceptCount, retireCount;
  int                         cycleCount;
  int                         issued;
  int                         assertFails;

  // ====================================================================
  // Clock, DUT and checker
  // ====================================================================
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  armCtrlTop u_armCtrlTop (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
    .stall(stall), .aluFlags(aluFlags), .addrLow(addrLow),
    .aluControlE(aluControlE), .aluSrcE(aluSrcE), .branchTakenE(branchTakenE),
    .memWriteM(memWriteM), .memToRegM(memToRegM), .byteMaskM(byteMaskM),
    .regWriteW(regWriteW), .memToRegW(memToRegW), .flags(flags)
  );

  armCtrlChecker u_armCtrlChecker (
    .clk(clk), .reset(reset), .stall(stall), .instr(instr),
    .instrValid(instrValid), .aluFlags(aluFlags), .addrLow(addrLow),
    .aluControlE(aluControlE), .aluSrcE(aluSrcE), .branchTakenE(branchTakenE),
    .memWriteM(memWriteM), .memToRegM(memToRegM), .byteMaskM(byteMaskM),
    .regWriteW(regWriteW), .memToRegW(memToRegW), .flags(flags),
    .errorCount(errorCount), .checkCount(checkCount),
    .acceptCount(acceptCount), .retireCount(retireCount)
  );

  // Mostly supported forms, any condition code including NV
  function automatic logic [`INSTR_WIDTH-1:0] randomInstr();
    logic [`INSTR_WIDTH-1:0] word;
    int                      pick;
    word = $urandom;
    pick = int'($urandom % 16);
    if (pick < 7) begin
      word[`CLASS_HI:`CLASS_LO] = 2'b00;  // Data processing
      if (!word[`IBIT])
        word[`REGSHIFT_BIT] = 1'b0;  // Shift by immediate
      if (word[`OPC_HI:`UBIT] == 2'b10)
        word[`SBIT] = ($urandom % 8) != 0;  // Compares nearly always set S
    end else if (pick < 11) begin
      word[`CLASS_HI:`CLASS_LO] = 2'b01;  // Load or store
      if (word[`IBIT])
        word[`REGSHIFT_BIT] = 1'b0;
    end else if (pick < 13) begin
      word[`CLASS_HI:`IBIT] = 3'b101;  // Branch
    end
    return word;  // Rest stay raw, often unsupported
  endfunction

  task automatic driveRandomInputs(input logic allowValid);
    stall      = ($urandom % 4) == 0;
    instrValid = allowValid && (($urandom % 10) < 8);
    instr      = randomInstr();
    aluFlags   = `FLAG_WIDTH'($urandom);
    addrLow    = `ADDR_LOW_WIDTH'($urandom);
  endtask

  // ====================================================================
  // Stimulus, falling edge
  // ====================================================================
  initial begin
    void'($urandom(SEED));
    reset      = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    stall      = 1'b0;
    aluFlags   = '0;
    addrLow    = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    issued = 0;
    while (issued < NUM_INSTR) begin
      @(negedge clk);
      driveRandomInputs(1'b1);
      if (instrValid && !stall)
        issued++;
    end
    // Drain, stalls still random
    while (retireCount < NUM_INSTR) begin
      @(negedge clk);
      driveRandomInputs(1'b0);
    end
    repeat (2) @(negedge clk);  // Last flag update reaches flags
    assertFails = u_armCtrlTop.u_armCtrlAssertions.failCount;
    $display("Checks %0d, errors %0d, assertion failures %0d, accepted %0d, retired %0d",
             checkCount, errorCount, assertFails, acceptCount, retireCount);
    if (errorCount == 0 && assertFails == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Cycle limit
  always @(posedge clk) begin
    if (reset)
      cycleCount <= 0;
    else
      cycleCount <= cycleCount + 1;
    if (!reset && cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions left writeback",
               cycleCount, retireCount, NUM_INSTR);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

// File: tests/armCtrlChecker.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module armCtrlChecker (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       stall,
  input  logic [`INSTR_WIDTH-1:0]    instr,
  input  logic                       instrValid,
  input  logic [`FLAG_WIDTH-1:0]     aluFlags,
  input  logic [`ADDR_LOW_WIDTH-1:0] addrLow,
  input  logic [`ALU_CTRL_WIDTH-1:0] aluControlE,
  input  logic                       aluSrcE,
  input  logic                       branchTakenE,
  input  logic                       memWriteM,
  input  logic                       memToRegM,
  input  logic [`MASK_WIDTH-1:0]     byteMaskM,
  input  logic                       regWriteW,
  input  logic                       memToRegW,
  input  logic [`FLAG_WIDTH-1:0]     flags,
  output int                         errorCount,
  output int                         checkCount,
  output int                         acceptCount,
  output int                         retireCount
);

  localparam logic [`ALU_CTRL_WIDTH-1:0] ALU_ADD = 4'd4;
  localparam logic [`ALU_CTRL_WIDTH-1:0] ALU_SUB = 4'd2;
  localparam logic [`FLAG_WIDTH-1:0]     NZ_BITS = `FLAG_WIDTH'((1 << `FLAG_N) | (1 << `FLAG_Z));

  // Expected behaviour of one instruction
  typedef struct packed {
    logic [1:0]                 kind;  // 0 DP, 1 LDST, 2 branch, 3 no-op
    logic [`ALU_CTRL_WIDTH-1:0] aluControl;
    logic                       aluSrc;
    logic                       branchTaken;
    logic                       memWrite;
    logic                       memToReg;
    logic [`MASK_WIDTH-1:0]     byteMask;
    logic                       regWrite;
    logic                       setFlags;
    logic [`FLAG_WIDTH-1:0]     nextFlags;
  } refCtrl_t;

  // Shadow pipeline
  logic                    exValidS, memValidS, wbValidS;
  logic [`INSTR_WIDTH-1:0] exInstrS;
  refCtrl_t                memRefS, wbRefS;
  int                      exSeqS, memSeqS, wbSeqS;
  logic [`FLAG_WIDTH-1:0]  progFlags;  // Flags in program order
  logic [`FLAG_WIDTH-1:0]  regFlags;   // Expected flags register

  // ====================================================================
  // Reference model
  // ====================================================================
  function automatic refCtrl_t refControl(
    input logic [`INSTR_WIDTH-1:0]    word,
    input logic [`FLAG_WIDTH-1:0]     alu,
    input logic [`ADDR_LOW_WIDTH-1:0] lane,
    input logic [`FLAG_WIDTH-1:0]     cur
  );
    refCtrl_t   r;
    logic [3:0] cond, opc;
    logic       n, z, c, v, pass, isCmp, isLogic, byteAcc, sBit, dpOk, lsOk, brOk;
    cond    = word[`COND_HI:`COND_LO];
    opc     = word[`OPC_HI:`OPC_LO];
    n       = cur[`FLAG_N];
    z       = cur[`FLAG_Z];
    c       = cur[`FLAG_C];
    v       = cur[`FLAG_V];
    isCmp   = opc[3:2] == 2'b10;  // TST TEQ CMP CMN
    isLogic = (opc inside {4'd0, 4'd1, 4'd8, 4'd9}) || opc[3:2] == 2'b11;
    case (cond)
      4'h0: pass = z;
      4'h1: pass = !z;
      4'h2: pass = c;
      4'h3: pass = !c;
      4'h4: pass = n;
      4'h5: pass = !n;
      4'h6: pass = v;
      4'h7: pass = !v;
      4'h8: pass = c && !z;
      4'h9: pass = !c || z;
      4'ha: pass = n == v;
      4'hb: pass = n != v;
      4'hc: pass = !z && n == v;
      4'hd: pass = z || n != v;
      4'he: pass = 1'b1;
      default: pass = 1'b0;
    endcase
    // Supported forms only and never with NV
    dpOk = cond != 4'hf && word[`CLASS_HI:`CLASS_LO] == 2'b00
        && (word[`IBIT] || !word[`REGSHIFT_BIT]) && (word[`SBIT] || !isCmp);
    lsOk = cond != 4'hf && word[`CLASS_HI:`CLASS_LO] == 2'b01
        && !(word[`IBIT] && word[`REGSHIFT_BIT]);
    brOk = cond != 4'hf && word[`CLASS_HI:`IBIT] == 3'b101;
    r            = '0;
    r.kind       = 2'd3;
    r.aluControl = ALU_ADD;
    byteAcc      = 1'b0;
    sBit         = 1'b0;
    if (dpOk) begin
      r.kind       = 2'd0;
      r.aluControl = opc;
      r.aluSrc     = word[`IBIT];
      r.regWrite   = pass && !isCmp;
      sBit         = word[`SBIT];
    end else if (lsOk) begin
      r.kind       = 2'd1;
      r.aluControl = word[`UBIT] ? ALU_ADD : ALU_SUB;
      r.aluSrc     = !word[`IBIT];
      r.regWrite   = pass && word[`LBIT];
      r.memToReg   = word[`LBIT];  // Load select is not condition gated
      r.memWrite   = pass && !word[`LBIT];
      byteAcc      = word[`BBIT];
    end else if (brOk) begin
      r.kind        = 2'd2;
      r.aluSrc      = 1'b1;
      r.branchTaken = pass;
    end
    r.setFlags = pass && sBit;
    // Logical ops keep C and V of the older flags
    if (dpOk && isLogic)
      r.nextFlags = (alu & NZ_BITS) | (cur & ~NZ_BITS);
    else
      r.nextFlags = alu;
    // Lane table for byte access
    if (!byteAcc)
      r.byteMask = 4'b1111;
    else begin
      case (lane)
        2'd0:    r.byteMask = 4'b0001;
        2'd1:    r.byteMask = 4'b0010;
        2'd2:    r.byteMask = 4'b0100;
        default: r.byteMask = 4'b1000;
      endcase
    end
    return r;
  endfunction

  function automatic string kindName(input logic [1:0] kind);
    case (kind)
      2'd0: return "dataProc";
      2'd1: return "loadStore";
      2'd2: return "branch";
      default: return "unsupported";
    endcase
  endfunction

  task automatic compareSignal(input string test, input string sig, input int seq,
                               input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERR %s #%0d %s: expected %h, actual %h at %0t",
               test, seq, sig, expected, actual, $time);
    end
  endtask

  // ====================================================================
  // Compare first and advance on unstalled edges
  // ====================================================================
  always @(posedge clk) begin : shadowPipe
    refCtrl_t exRef;
    string    idle;
    if (reset) begin
      exValidS    = 1'b0;
      memValidS   = 1'b0;
      wbValidS    = 1'b0;
      progFlags   = '0;
      regFlags    = '0;
      errorCount  = 0;
      checkCount  = 0;
      acceptCount = 0;
      retireCount = 0;
    end else begin
      exRef = refControl(exInstrS, aluFlags, addrLow, progFlags);
      idle  = (acceptCount == 0) ? "reset" : "bubble";
      if (exValidS) begin
        compareSignal(kindName(exRef.kind), "aluControlE", exSeqS,
                      32'(exRef.aluControl), 32'(aluControlE));
        compareSignal(kindName(exRef.kind), "aluSrcE", exSeqS,
                      32'(exRef.aluSrc), 32'(aluSrcE));
        compareSignal(kindName(exRef.kind), "branchTakenE", exSeqS,
                      32'(exRef.branchTaken), 32'(branchTakenE));
      end else
        compareSignal(idle, "branchTakenE", -1, 0, 32'(branchTakenE));
      if (memValidS) begin
        compareSignal(kindName(memRefS.kind), "memWriteM", memSeqS,
                      32'(memRefS.memWrite), 32'(memWriteM));
        compareSignal(kindName(memRefS.kind), "memToRegM", memSeqS,
                      32'(memRefS.memToReg), 32'(memToRegM));
        compareSignal(kindName(memRefS.kind), "byteMaskM", memSeqS,
                      32'(memRefS.byteMask), 32'(byteMaskM));
      end else begin
        compareSignal(idle, "memWriteM", -1, 0, 32'(memWriteM));
        compareSignal(idle, "memToRegM", -1, 0, 32'(memToRegM));
      end
      if (wbValidS) begin
        compareSignal(kindName(wbRefS.kind), "regWriteW", wbSeqS,
                      32'(wbRefS.regWrite), 32'(regWriteW));
        compareSignal(kindName(wbRefS.kind), "memToRegW", wbSeqS,
                      32'(wbRefS.memToReg), 32'(memToRegW));
      end else begin
        compareSignal(idle, "regWriteW", -1, 0, 32'(regWriteW));
        compareSignal(idle, "memToRegW", -1, 0, 32'(memToRegW));
      end
      compareSignal("flagsUpdate", "flags", retireCount, 32'(regFlags), 32'(flags));
      if (!stall) begin
        if (wbValidS) begin
          if (wbRefS.setFlags)
            regFlags = wbRefS.nextFlags;  // Visible one edge later
          retireCount++;
        end
        wbValidS  = memValidS;
        wbRefS    = memRefS;
        wbSeqS    = memSeqS;
        memValidS = exValidS;
        memRefS   = exRef;
        memSeqS   = exSeqS;
        if (exValidS && exRef.setFlags)
          progFlags = exRef.nextFlags;  // Seen by the next instruction
        exValidS = instrValid;
        exInstrS = instr;
        exSeqS   = acceptCount;
        if (instrValid)
          acceptCount++;
      end
    end
  end

endmodule

// File: tests/armCtrl_assertions.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module armCtrlAssertions (
  input logic                       clk,
  input logic                       reset,
  input logic                       stall,
  input logic [`ALU_CTRL_WIDTH-1:0] aluControlE,
  input logic                       aluSrcE,
  input logic                       branchTakenE,
  input logic                       memWriteM,
  input logic                       memToRegM,
  input logic [`MASK_WIDTH-1:0]     byteMaskM,
  input logic                       regWriteW,
  input logic                       memToRegW,
  input logic [`FLAG_WIDTH-1:0]     flags
);

  int failCount = 0;  // Failed assertions so far

  // ====================================================================
  // Stall freezes every stage
  // ====================================================================
  holdExecute: assert property (@(posedge clk) disable iff (reset)
      stall |=> $stable({aluControlE, aluSrcE, branchTakenE}))
    else begin
      failCount++;
      $error("execute outputs changed while stalled");
    end

  holdMemory: assert property (@(posedge clk) disable iff (reset)
      stall |=> $stable({memWriteM, memToRegM, byteMaskM}))
    else begin
      failCount++;
      $error("memory outputs changed while stalled");
    end

  holdWriteback: assert property (@(posedge clk) disable iff (reset)
      stall |=> $stable({regWriteW, memToRegW, flags}))
    else begin
      failCount++;
      $error("writeback outputs or flags changed while stalled");
    end

  // Store lanes, a full word or a single byte
  maskShape: assert property (@(posedge clk) disable iff (reset)
      memWriteM |-> (byteMaskM == {`MASK_WIDTH{1'b1}} || $onehot(byteMaskM)))
    else begin
      failCount++;
      $error("store byte mask is neither full nor one-hot");
    end

  // Pipeline empty right after reset
  noBranchAfterReset: assert property (@(posedge clk) $fell(reset) |-> !branchTakenE)
    else begin
      failCount++;
      $error("branch taken in the first cycle after reset");
    end

endmodule

bind armCtrlTop armCtrlAssertions u_armCtrlAssertions (
  .clk(clk), .reset(reset), .stall(stall),
  .aluControlE(aluControlE), .aluSrcE(aluSrcE), .branchTakenE(branchTakenE),
  .memWriteM(memWriteM), .memToRegM(memToRegM), .byteMaskM(byteMaskM),
  .regWriteW(regWriteW), .memToRegW(memToRegW), .flags(flags)
);

// File: src/armCtrlTop.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module armCtrlTop (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`INSTR_WIDTH-1:0]    instr,
  input  logic                       instrValid,
  input  logic                       stall,         // freezes every stage
  input  logic [`FLAG_WIDTH-1:0]     aluFlags,      // NZCV of the op in execute
  input  logic [`ADDR_LOW_WIDTH-1:0] addrLow,       // execute address [1:0]
  output logic [`ALU_CTRL_WIDTH-1:0] aluControlE,
  output logic                       aluSrcE,
  output logic                       branchTakenE,
  output logic                       memWriteM,
  output logic                       memToRegM,
  output logic [`MASK_WIDTH-1:0]     byteMaskM,
  output logic                       regWriteW,
  output logic                       memToRegW,
  output logic [`FLAG_WIDTH-1:0]     flags
);

  armCtrlPkg::execCtrl_t decodedD, exCtrl;
  armCtrlPkg::memCtrl_t  nextMem, memCtrl;
  armCtrlPkg::wbCtrl_t   wbIn, wbCtrl;
  logic                  exValid, memValid, wbValid;

  // ==================================================================
  // Decode
  // ==================================================================
  instrDecoder u_instrDecoder (.instr(instr), .decoded(decodedD));

  pipeStage #(.payload_t(armCtrlPkg::execCtrl_t)) u_exStage (
    .clk(clk), .reset(reset), .stall(stall),
    .inValid(instrValid), .inData(decodedD),
    .outValid(exValid), .outData(exCtrl)
  );

  // ==================================================================
  // Execute
  // ==================================================================
  condExecute u_condExecute (
    .exValid(exValid), .exCtrl(exCtrl),
    .aluFlags(aluFlags), .addrLow(addrLow),
    .memValid(memValid), .memCtrl(memCtrl),
    .wbValid(wbValid), .wbCtrl(wbCtrl),
    .flags(flags),
    .nextMem(nextMem),
    .aluControlE(aluControlE), .aluSrcE(aluSrcE), .branchTakenE(branchTakenE)
  );

  pipeStage #(.payload_t(armCtrlPkg::memCtrl_t)) u_memStage (
    .clk(clk), .reset(reset), .stall(stall),
    .inValid(exValid), .inData(nextMem),
    .outValid(memValid), .outData(memCtrl)
  );

  // ==================================================================
  // Memory
  // ==================================================================
  assign memWriteM = memValid & memCtrl.memWrite;  // bubble never writes
  assign memToRegM = memValid & memCtrl.memToReg;
  assign byteMaskM = memCtrl.byteMask;

  // Byte lanes dropped on the way to writeback
  assign wbIn = '{regWrite:  memCtrl.regWrite,
                  memToReg:  memCtrl.memToReg,
                  setFlags:  memCtrl.setFlags,
                  nextFlags: memCtrl.nextFlags};

  pipeStage #(.payload_t(armCtrlPkg::wbCtrl_t)) u_wbStage (
    .clk(clk), .reset(reset), .stall(stall),
    .inValid(memValid), .inData(wbIn),
    .outValid(wbValid), .outData(wbCtrl)
  );

  // ==================================================================
  // Writeback
  // ==================================================================
  flagsReg u_flagsReg (
    .clk(clk), .reset(reset), .stall(stall),
    .wbValid(wbValid), .wbCtrl(wbCtrl),
    .flags(flags), .regWriteW(regWriteW), .memToRegW(memToRegW)
  );

endmodule

// File: src/flagsReg.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module flagsReg (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   wbValid,
  input  armCtrlPkg::wbCtrl_t    wbCtrl,
  output logic [`FLAG_WIDTH-1:0] flags,      // NZCV
  output logic                   regWriteW,
  output logic                   memToRegW
);

  // Update at the end of writeback
  always_ff @(posedge clk) begin
    if (reset)
      flags <= '0;
    else if (wbValid && wbCtrl.setFlags && !stall)
      flags <= wbCtrl.nextFlags;  // condition already folded into setFlags
  end

  // Writeback enables, low for a bubble
  assign regWriteW = wbValid & wbCtrl.regWrite;
  assign memToRegW = wbValid & wbCtrl.memToReg;

endmodule

// File: execute/condExecute.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module condExecute (
  input  logic                       exValid,
  input  armCtrlPkg::execCtrl_t      exCtrl,
  input  logic [`FLAG_WIDTH-1:0]     aluFlags,
  input  logic [`ADDR_LOW_WIDTH-1:0] addrLow,
  input  logic                       memValid,
  input  armCtrlPkg::memCtrl_t       memCtrl,
  input  logic                       wbValid,
  input  armCtrlPkg::wbCtrl_t        wbCtrl,
  input  logic [`FLAG_WIDTH-1:0]     flags,
  output armCtrlPkg::memCtrl_t       nextMem,
  output logic [`ALU_CTRL_WIDTH-1:0] aluControlE,
  output logic                       aluSrcE,
  output logic                       branchTakenE
);

  logic [`FLAG_WIDTH-1:0] curFlags;  // flags as seen in program order
  logic [`FLAG_WIDTH-1:0] flagsNext;
  logic                   nFlag, zFlag, cFlag, vFlag;
  logic                   condPass, doIt;

  // ==================================================================
  // Flag forwarding
  // ==================================================================
  // Youngest producer wins
  always_comb begin
    if (memValid && memCtrl.setFlags)
      curFlags = memCtrl.nextFlags;
    else if (wbValid && wbCtrl.setFlags)
      curFlags = wbCtrl.nextFlags;
    else
      curFlags = flags;
  end

  assign nFlag = curFlags[`FLAG_N];
  assign zFlag = curFlags[`FLAG_Z];
  assign cFlag = curFlags[`FLAG_C];
  assign vFlag = curFlags[`FLAG_V];

  // ==================================================================
  // Condition check
  // ==================================================================
  always_comb begin
    case (exCtrl.cond)
      armIsaPkg::EQ: condPass = zFlag;
      armIsaPkg::NE: condPass = ~zFlag;
      armIsaPkg::CS: condPass = cFlag;
      armIsaPkg::CC: condPass = ~cFlag;
      armIsaPkg::MI: condPass = nFlag;
      armIsaPkg::PL: condPass = ~nFlag;
      armIsaPkg::VS: condPass = vFlag;
      armIsaPkg::VC: condPass = ~vFlag;
      armIsaPkg::HI: condPass = cFlag & ~zFlag;
      armIsaPkg::LS: condPass = ~cFlag | zFlag;
      armIsaPkg::GE: condPass = (nFlag == vFlag);
      armIsaPkg::LT: condPass = (nFlag != vFlag);
      armIsaPkg::GT: condPass = ~zFlag & (nFlag == vFlag);
      armIsaPkg::LE: condPass = zFlag | (nFlag != vFlag);
      armIsaPkg::AL: condPass = 1'b1;
      default:       condPass = 1'b0;  // NV never runs
    endcase
  end

  assign doIt = exValid & condPass;

  // Logical ops take only N and Z from the ALU
  assign flagsNext = (exCtrl.flagKind == armCtrlPkg::FLAG_LOGIC)
                   ? {aluFlags[`FLAG_N], aluFlags[`FLAG_Z], cFlag, vFlag}
                   : aluFlags;

  // ==================================================================
  // Memory payload
  // ==================================================================
  assign nextMem.memWrite  = doIt & exCtrl.memWrite;
  assign nextMem.memToReg  = exValid & exCtrl.memToReg;
  assign nextMem.regWrite  = doIt & exCtrl.regWrite;
  assign nextMem.setFlags  = doIt & exCtrl.sBit;
  assign nextMem.nextFlags = flagsNext;
  // One lane for byte access, all four for a word
  assign nextMem.byteMask  = exCtrl.byteAccess ? (`MASK_WIDTH'(1) << addrLow)
                                               : {`MASK_WIDTH{1'b1}};

  // Execute-stage outputs to the datapath
  assign aluControlE  = exCtrl.aluControl;
  assign aluSrcE      = exCtrl.aluSrc;
  assign branchTakenE = doIt & exCtrl.branch;

endmodule

// File: src/pipeStage.sv
`timescale 1ns/1ps

module pipeStage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     inValid,
  input  payload_t inData,
  output logic     outValid,
  output payload_t outData
);

  // Valid bit, cleared on reset
  always_ff @(posedge clk) begin
    if (reset)
      outValid <= 1'b0;
    else if (!stall)
      outValid <= inValid;  // bubble when inValid low
  end

  // Payload follows valid
  always_ff @(posedge clk) begin
    if (!stall)
      outData <= inData;
  end

endmodule

// File: decode/instrDecoder.sv
`timescale 1ns/1ps
`include "armCtrl_settings.svh"

module instrDecoder (
  input  logic [`INSTR_WIDTH-1:0] instr,
  output armCtrlPkg::execCtrl_t   decoded
);

  armIsaPkg::condCode_t   cond;
  armIsaPkg::dpOpcode_t   opcode;
  armIsaPkg::instrClass_t rawClass;  // straight from the class bits
  armIsaPkg::instrClass_t iClass;    // after form checks
  logic                   dpForm, ldstForm, branchForm;

  assign cond     = armIsaPkg::condCode_t'(instr[`COND_HI:`COND_LO]);
  assign opcode   = armIsaPkg::dpOpcode_t'(instr[`OPC_HI:`OPC_LO]);
  assign rawClass = armIsaPkg::instrClass_t'(instr[`CLASS_HI:`CLASS_LO]);

  // Immediate, or register shifted by immediate
  // Compare without S is the misc space (MRS, MSR, BX, CLZ)
  assign dpForm = (instr[`IBIT] | ~instr[`REGSHIFT_BIT])
                & (instr[`SBIT] | ~armIsaPkg::isCompare(opcode));

  // Register offset with bit 4 set is undefined
  assign ldstForm = ~(instr[`IBIT] & instr[`REGSHIFT_BIT]);

  // 100 is LDM/STM
  assign branchForm = instr[`IBIT];

  // Classify, anything unrecognised or NV becomes a no-op
  always_comb begin
    iClass = armIsaPkg::CLS_NONE;
    if (cond != armIsaPkg::NV) begin
      case (rawClass)
        armIsaPkg::CLS_DP:     if (dpForm)     iClass = armIsaPkg::CLS_DP;
        armIsaPkg::CLS_LDST:   if (ldstForm)   iClass = armIsaPkg::CLS_LDST;
        armIsaPkg::CLS_BRANCH: if (branchForm) iClass = armIsaPkg::CLS_BRANCH;
        default:               iClass = armIsaPkg::CLS_NONE;
      endcase
    end
  end

  // ==================================================================
  // Control payload
  // ==================================================================
  always_comb begin
    decoded            = '0;  // no-op unless a form below matches
    decoded.cond       = cond;
    decoded.opcode     = opcode;
    decoded.aluControl = armIsaPkg::OP_ADD;
    decoded.flagKind   = armCtrlPkg::FLAG_ARITH;
    case (iClass)
      armIsaPkg::CLS_DP: begin
        decoded.aluControl = opcode;
        decoded.aluSrc     = instr[`IBIT];
        decoded.sBit       = instr[`SBIT];
        if (armIsaPkg::isLogical(opcode))
          decoded.flagKind = armCtrlPkg::FLAG_LOGIC;  // keeps C and V
        decoded.regWrite   = ~armIsaPkg::isCompare(opcode);
      end
      armIsaPkg::CLS_LDST: begin
        // Offset direction from U
        decoded.aluControl = instr[`UBIT] ? armIsaPkg::OP_ADD : armIsaPkg::OP_SUB;
        decoded.aluSrc     = ~instr[`IBIT];  // I clear means 12-bit immediate
        decoded.regWrite   = instr[`LBIT];
        decoded.memToReg   = instr[`LBIT];
        decoded.memWrite   = ~instr[`LBIT];
        decoded.byteAccess = instr[`BBIT];
      end
      armIsaPkg::CLS_BRANCH: begin
        decoded.aluSrc = 1'b1;  // PC plus offset
        decoded.branch = 1'b1;
      end
      default: begin
        decoded.aluSrc = 1'b0;  // every enable stays low
      end
    endcase
  end

endmodule

// File: common/armCtrlPkg.sv
`include "armCtrl_settings.svh"

package armCtrlPkg;

  // How a flag-setting op builds NZCV
  typedef enum logic {
    FLAG_ARITH = 1'b0,  // all four from the ALU
    FLAG_LOGIC = 1'b1   // N and Z only
  } flagKind_t;

  // Decode to execute
  typedef struct packed {
    armIsaPkg::condCode_t           cond;
    armIsaPkg::dpOpcode_t           opcode;      // instruction opcode field
    logic [`ALU_CTRL_WIDTH-1:0]     aluControl;  // op the ALU runs
    logic                           aluSrc;      // 1 = immediate operand
    logic                           sBit;
    flagKind_t                      flagKind;
    logic                           regWrite;
    logic                           memWrite;
    logic                           memToReg;
    logic                           byteAccess;
    logic                           branch;
  } execCtrl_t;

  // Execute to memory, enables already condition gated
  typedef struct packed {
    logic                   memWrite;
    logic                   memToReg;
    logic                   regWrite;
    logic [`MASK_WIDTH-1:0] byteMask;
    logic                   setFlags;
    logic [`FLAG_WIDTH-1:0] nextFlags;
  } memCtrl_t;

  // Memory to writeback, byte lanes no longer needed
  typedef struct packed {
    logic                   regWrite;
    logic                   memToReg;
    logic                   setFlags;
    logic [`FLAG_WIDTH-1:0] nextFlags;
  } wbCtrl_t;

endpackage

// File: common/armIsaPkg.sv
`include "armCtrl_settings.svh"

package armIsaPkg;

  // Condition field, NV marks the unconditional space
  typedef enum logic [`COND_HI-`COND_LO:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condCode_t;

  // Data-processing opcodes, same encoding as instr[24:21]
  typedef enum logic [`ALU_CTRL_WIDTH-1:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } dpOpcode_t;

  // Class bits instr[27:26]; 11 has no supported form
  typedef enum logic [`CLASS_HI-`CLASS_LO:0] {
    CLS_DP     = 2'b00,
    CLS_LDST   = 2'b01,
    CLS_BRANCH = 2'b10,
    CLS_NONE   = 2'b11
  } instrClass_t;

  // Logical ops leave C and V alone
  function automatic logic isLogical(dpOpcode_t op);
    return op inside {OP_AND, OP_EOR, OP_TST, OP_TEQ,
                      OP_ORR, OP_MOV, OP_BIC, OP_MVN};
  endfunction

  // Compares only update flags
  function automatic logic isCompare(dpOpcode_t op);
    return op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
  endfunction

endpackage

// File: common/armCtrl_settings.svh
`ifndef ARMCTRL_SETTINGS_SVH
`define ARMCTRL_SETTINGS_SVH

// Widths
`define INSTR_WIDTH    32
`define FLAG_WIDTH     4   // NZCV
`define ALU_CTRL_WIDTH 4
`define MASK_WIDTH     4   // one bit per byte lane
`define ADDR_LOW_WIDTH 2   // selects the byte lane

// Instruction field positions
`define COND_HI      31
`define COND_LO      28
`define CLASS_HI     27
`define CLASS_LO     26
`define IBIT         25  // immediate operand / register offset
`define OPC_HI       24
`define OPC_LO       21
`define UBIT         23  // add or subtract offset
`define BBIT         22  // byte access
`define SBIT         20  // set flags
`define LBIT         20  // load, shares the S position
`define REGSHIFT_BIT 4   // register-shifted register operand

// Positions inside NZCV
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0

`endif
